// File: src/wb_pkg.sv
package wb_pkg;

    ////////////////////////////////////////////////////////////
    // Data path widths
    ////////////////////////////////////////////////////////////

    localparam int XLEN = 64;              // RV64 register width

    typedef logic [XLEN-1:0] word_t;       // Register file data
    typedef logic [4:0]      reg_idx_t;    // x0..x31
    typedef logic [2:0]      byte_off_t;   // Byte lane in a doubleword

    // Retirement order, full 64 bits on the port
    // Internal counter may be narrower, see ORDER_W in wb_retire
    typedef logic [63:0]     order_t;

    ////////////////////////////////////////////////////////////
    // Load access width
    ////////////////////////////////////////////////////////////

    // One-hot from the decoder, any other pattern is invalid
    typedef enum logic [3:0] {
        MEM_BYTE   = 4'b0001,  // LB / LBU
        MEM_HALF   = 4'b0010,  // LH / LHU
        MEM_WORD   = 4'b0100,  // LW / LWU
        MEM_DOUBLE = 4'b1000   // LD
    } mem_width_e;

endpackage

// File: src/wb_load_if.sv
// Load request from the memory stage, level signals only
interface wb_load_if (
    input logic clk_i    // Sampling clock for sink side checks
);

    wb_pkg::word_t      rdata;      // Raw 64-bit read data
    wb_pkg::mem_width_e width;      // Access width, one-hot
    logic               sign_ext;   // 1 = signed load
    wb_pkg::byte_off_t  byte_off;   // Address bits [2:0]

    // Stage top drives the request
    modport src (
        output rdata, width, sign_ext, byte_off
    );

    // Aligner consumes it
    modport sink (
        input clk_i,
        input rdata, width, sign_ext, byte_off
    );

endinterface

// File: src/wb_validity.sv
module wb_validity (
    input  logic clk_i,
    input  logic rst_ni,
    input  logic valid_i,     // Valid from the memory stage
    input  logic squash_i,    // Flush from branch or trap
    input  logic bubble_i,    // Bubble insertion
    input  logic stall_i,     // Stage held this cycle
    output logic valid_o      // Tracked valid
);

    ////////////////////////////////////////////////////////////
    // Kill tracking
    ////////////////////////////////////////////////////////////

    logic kill_req;   // Squash or bubble this cycle
    logic kill_q;     // Kill seen while stalled

    assign kill_req = squash_i | bubble_i;

    // A flush can arrive while the stage is held
    // Without this flag it would vanish once squash_i drops,
    // and the held instruction would write after the stall
    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            kill_q <= 1'b0;
        end else if (stall_i) begin
            kill_q <= kill_q | kill_req;    // Accumulate while held
        end else begin
            kill_q <= 1'b0;                 // Cleared at first free edge
        end
    end

    ////////////////////////////////////////////////////////////
    // Tracked valid
    ////////////////////////////////////////////////////////////

    // Combinational, feeds write logic and retire logic alike
    assign valid_o = valid_i    // Instruction present
                   & ~kill_req  // Not killed now
                   & ~kill_q;   // Not killed during a stall

endmodule

// File: src/wb_load_align.sv
module wb_load_align (
    wb_load_if.sink       ld,            // Read data, width, sign, offset
    output wb_pkg::word_t load_data_o    // Aligned and extended result
);

    ////////////////////////////////////////////////////////////
    // Lane select
    ////////////////////////////////////////////////////////////

    logic [7:0]  lane_b;   // Byte at any offset
    logic [15:0] lane_h;   // Halfword, offset bit 0 ignored
    logic [31:0] lane_w;   // Word, only offset bit 2 matters
    logic        msb;      // Fill bit for the upper part

    // Bit offset built from the byte offset
    assign lane_b = ld.rdata[{ld.byte_off, 3'b000} +: 8];
    assign lane_h = ld.rdata[{ld.byte_off[2:1], 4'b0000} +: 16];
    assign lane_w = ld.rdata[{ld.byte_off[2], 5'b00000} +: 32];

    ////////////////////////////////////////////////////////////
    // Extension
    ////////////////////////////////////////////////////////////

    always_comb begin
        msb         = 1'b0;
        load_data_o = '0;   // Invalid width reads as zero
        case (ld.width)
            wb_pkg::MEM_BYTE: begin
                msb         = ld.sign_ext & lane_b[7];
                load_data_o = {{(wb_pkg::XLEN-8){msb}}, lane_b};
            end
            wb_pkg::MEM_HALF: begin
                msb         = ld.sign_ext & lane_h[15];
                load_data_o = {{(wb_pkg::XLEN-16){msb}}, lane_h};
            end
            wb_pkg::MEM_WORD: begin
                msb         = ld.sign_ext & lane_w[31];   // LW vs LWU
                load_data_o = {{(wb_pkg::XLEN-32){msb}}, lane_w};
            end
            wb_pkg::MEM_DOUBLE: begin
                load_data_o = ld.rdata;   // Full width, nothing to extend
            end
            default: begin
                load_data_o = '0;
            end
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////

    // Width comes from the decoder through the top; must never float
    a_width_known: assert property (
        @(posedge ld.clk_i) !$isunknown(ld.width)
    ) else $error("wb_load_align: load width has unknown bits");

endmodule

// File: src/wb_rf_write.sv
module wb_rf_write (
    input  logic             clk_i,
    input  logic             rst_ni,
    input  logic             stall_i,        // Hold outputs, suppress write
    input  logic             valid_i,        // Tracked valid
    input  wb_pkg::word_t    pc_i,           // Identifies the instruction
    input  wb_pkg::word_t    rd_data_i,      // Pipeline result
    input  wb_pkg::word_t    load_data_i,    // Aligned load result
    input  wb_pkg::reg_idx_t rd_idx_i,       // Destination register
    input  logic             rd_wr_en_i,     // Decoder write enable
    input  logic             rd_src_load_i,  // 1 = take load result
    output wb_pkg::word_t    rd_data_o,      // To register file
    output wb_pkg::reg_idx_t rd_idx_o,
    output logic             rd_wr_en_o,     // One pulse per instruction
    output logic             valid_o         // Aligned with rd_wr_en_o
);

    ////////////////////////////////////////////////////////////
    // Write decision
    ////////////////////////////////////////////////////////////

    wb_pkg::word_t    last_pc_q;     // pc at last free edge
    wb_pkg::reg_idx_t last_idx_q;    // rd at last free edge
    logic             written_q;     // Current instruction already wrote
    logic             instr_changed;
    logic             should_write;
    wb_pkg::word_t    wr_data;

    // New instruction when pc or destination moved
    assign instr_changed = (pc_i != last_pc_q) || (rd_idx_i != last_idx_q);

    // The same instruction may sit here for several cycles
    assign should_write = valid_i & rd_wr_en_i & (~written_q | instr_changed);

    assign wr_data = rd_src_load_i ? load_data_i : rd_data_i;   // Result mux

    ////////////////////////////////////////////////////////////
    // Control registers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            rd_wr_en_o <= 1'b0;
            valid_o    <= 1'b0;
            written_q  <= 1'b0;
            last_pc_q  <= '0;
            last_idx_q <= '0;
        end else if (!stall_i) begin
            rd_wr_en_o <= should_write;
            valid_o    <= valid_i;
            last_pc_q  <= pc_i;
            last_idx_q <= rd_idx_i;
            if (should_write) begin
                written_q <= 1'b1;               // Mark done
            end else if (instr_changed || !valid_i) begin
                written_q <= 1'b0;               // Rearm for the next one
            end
        end else begin
            // Held: no write, no valid, written flag kept
            rd_wr_en_o <= 1'b0;
            valid_o    <= 1'b0;
        end
    end

    ////////////////////////////////////////////////////////////
    // Data registers
    ////////////////////////////////////////////////////////////

    // Qualified by rd_wr_en_o downstream
    always_ff @(posedge clk_i) begin
        if (!stall_i) begin
            rd_data_o <= wr_data;
            rd_idx_o  <= rd_idx_i;
        end
    end

    // A stalled edge must never produce a register file write
    a_no_write_after_stall: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        stall_i |=> !rd_wr_en_o
    ) else $error("wb_rf_write: write enable high after a stalled edge");

endmodule

// File: src/wb_retire.sv
module wb_retire #(
    parameter int ORDER_W = 64      // Counter width
) (
    input  logic           clk_i,
    input  logic           rst_ni,
    input  logic           valid_i,         // Tracked valid
    input  logic           stall_i,         // No retirement while held
    output logic           retired_o,       // Retire strobe
    output wb_pkg::order_t retire_order_o   // Order of this retirement
);

    ////////////////////////////////////////////////////////////
    // Retire strobe
    ////////////////////////////////////////////////////////////

    // Zero cycles from the inputs
    assign retired_o = valid_i & ~stall_i;

    ////////////////////////////////////////////////////////////
    // Order counter
    ////////////////////////////////////////////////////////////

    logic [ORDER_W-1:0] order_q;   // Retirements so far

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            order_q <= '0;
        end else if (retired_o) begin
            order_q <= order_q + ORDER_W'(1);   // One per retired instruction
        end
    end

    // Count before the increment, so the first retirement is order 0
    assign retire_order_o = wb_pkg::order_t'(order_q);

endmodule

// File: src/wb_stage.sv
module wb_stage #(
    parameter int ORDER_W = 64                   // Retirement counter width
) (
    input  logic               clk_i,
    input  logic               rst_ni,
    // Pipeline control
    input  logic               squash_i,
    input  logic               bubble_i,
    input  logic               stall_i,
    input  logic               valid_i,
    // Instruction and result
    input  wb_pkg::word_t      pc_i,
    input  wb_pkg::word_t      rd_data_i,         // ALU or other result
    input  wb_pkg::reg_idx_t   rd_idx_i,
    input  logic               rd_wr_en_i,
    input  logic               rd_src_load_i,     // Result comes from memory
    // Load data from data memory
    input  wb_pkg::word_t      dmem_rdata_i,
    input  logic               mem_sign_i,
    input  wb_pkg::mem_width_e mem_width_i,
    input  wb_pkg::byte_off_t  byte_off_i,
    // Register file write port
    output wb_pkg::word_t      rd_data_o,
    output wb_pkg::reg_idx_t   rd_idx_o,
    output logic               rd_wr_en_o,
    output logic               valid_o,
    // Retirement
    output logic               retired_o,
    output wb_pkg::order_t     retire_order_o
);

    wb_pkg::word_t load_data;   // Aligner result
    logic          valid;       // Tracked valid

    ////////////////////////////////////////////////////////////
    // Load request
    ////////////////////////////////////////////////////////////

    wb_load_if load_if (.clk_i(clk_i));

    assign load_if.rdata    = dmem_rdata_i;
    assign load_if.width    = mem_width_i;
    assign load_if.sign_ext = mem_sign_i;
    assign load_if.byte_off = byte_off_i;

    ////////////////////////////////////////////////////////////
    // Submodules
    ////////////////////////////////////////////////////////////

    wb_validity u_validity (
        .clk_i    (clk_i),
        .rst_ni   (rst_ni),
        .valid_i  (valid_i),
        .squash_i (squash_i),
        .bubble_i (bubble_i),
        .stall_i  (stall_i),
        .valid_o  (valid)
    );

    wb_load_align u_load_align (
        .ld          (load_if.sink),
        .load_data_o (load_data)
    );

    wb_rf_write u_rf_write (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .stall_i       (stall_i),
        .valid_i       (valid),
        .pc_i          (pc_i),
        .rd_data_i     (rd_data_i),
        .load_data_i   (load_data),
        .rd_idx_i      (rd_idx_i),
        .rd_wr_en_i    (rd_wr_en_i),
        .rd_src_load_i (rd_src_load_i),
        .rd_data_o     (rd_data_o),
        .rd_idx_o      (rd_idx_o),
        .rd_wr_en_o    (rd_wr_en_o),
        .valid_o       (valid_o)
    );

    wb_retire #(
        .ORDER_W (ORDER_W)
    ) u_retire (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .valid_i        (valid),
        .stall_i        (stall_i),
        .retired_o      (retired_o),
        .retire_order_o (retire_order_o)
    );

endmodule

// File: test/wb_checker.sv
module wb_checker (
    input  logic               clk_i,
    input  logic               rst_ni,
    input  logic               squash_i,
    input  logic               bubble_i,
    input  logic               stall_i,
    input  logic               valid_i,
    input  wb_pkg::word_t      pc_i,
    input  wb_pkg::word_t      rd_data_i,
    input  wb_pkg::reg_idx_t   rd_idx_i,
    input  logic               rd_wr_en_i,
    input  logic               rd_src_load_i,
    input  wb_pkg::word_t      dmem_rdata_i,
    input  logic               mem_sign_i,
    input  wb_pkg::mem_width_e mem_width_i,
    input  wb_pkg::byte_off_t  byte_off_i,
    input  wb_pkg::word_t      rd_data_o,
    input  wb_pkg::reg_idx_t   rd_idx_o,
    input  logic               rd_wr_en_o,
    input  logic               valid_o,
    input  logic               retired_o,
    input  wb_pkg::order_t     retire_order_o,
    input  int                 test_num_i      // 0 = idle, no test running
);
    timeunit 1ns;
    timeprecision 1ps;

    // Reference model state
    wb_pkg::word_t    last_pc;
    wb_pkg::reg_idx_t last_idx;
    logic             written;
    logic             kill_flag;
    logic             exp_wr_en;
    logic             exp_valid;
    wb_pkg::word_t    exp_data;
    wb_pkg::reg_idx_t exp_idx;
    wb_pkg::order_t   exp_order;
    logic             have_data;       // Data register loaded at least once
    int               cur_test = 0;    // Test that produced the expectation
    int               prev_test = 0;
    int               test_errs = 0;
    int               error_count = 0;
    int               tests_done = 0;
    logic             idle_seen = 1'b0;

    // Load result from the alignment rules, by shifting the lane down
    function automatic wb_pkg::word_t expect_load(input wb_pkg::word_t rdata,
                                                  input logic [3:0] width,
                                                  input logic sign,
                                                  input logic [2:0] off);
        wb_pkg::word_t sh;
        wb_pkg::word_t res;
        res = '0;
        case (width)
            4'b0001: begin
                sh  = rdata >> (off * 8);
                res = {56'd0, sh[7:0]};
                if (sign && sh[7]) res[63:8] = '1;
            end
            4'b0010: begin
                sh  = rdata >> ((off & 3'd6) * 8);   // Halfword ignores bit 0
                res = {48'd0, sh[15:0]};
                if (sign && sh[15]) res[63:16] = '1;
            end
            4'b0100: begin
                sh  = rdata >> ((off & 3'd4) * 8);
                res = {32'd0, sh[31:0]};
                if (sign && sh[31]) res[63:32] = '1;
            end
            4'b1000: res = rdata;
            default: res = '0;                       // Unknown width
        endcase
        return res;
    endfunction

    function automatic logic live_valid();
        return valid_i & ~squash_i & ~bubble_i & ~kill_flag;
    endfunction

    //////////////////////////////////////////////////////////////
    // Model update on the clock edge, inputs only
    //////////////////////////////////////////////////////////////

    always @(posedge clk_i) begin
        logic v;
        logic changed;
        logic sw;
        v = live_valid();
        cur_test = test_num_i;
        if (!rst_ni) begin
            {exp_wr_en, exp_valid, written, kill_flag, have_data} = '0;
            last_pc = '0;
            last_idx = '0;
            exp_order = '0;
        end else begin
            if (!stall_i) begin
                changed   = (pc_i != last_pc) || (rd_idx_i != last_idx);
                sw        = v & rd_wr_en_i & (~written | changed);
                exp_wr_en = sw;
                exp_valid = v;
                exp_data  = rd_src_load_i ?
                    expect_load(dmem_rdata_i, mem_width_i, mem_sign_i, byte_off_i) :
                    rd_data_i;
                exp_idx   = rd_idx_i;
                have_data = 1'b1;
                if (sw) written = 1'b1;
                else if (changed || !v) written = 1'b0;
                last_pc   = pc_i;
                last_idx  = rd_idx_i;
                if (v) exp_order = exp_order + 1;   // Retired this cycle
                kill_flag = 1'b0;
            end else begin
                exp_wr_en = 1'b0;
                exp_valid = 1'b0;
                kill_flag = kill_flag | squash_i | bubble_i;   // Sticky in a stall
            end
        end
    end

    //////////////////////////////////////////////////////////////
    // Compare on the falling edge, outputs are settled
    //////////////////////////////////////////////////////////////

    task automatic flag(input string what, input logic [63:0] got, input logic [63:0] exp);
        $display("ERROR at %0t: test %0d, %s is %h, expected %h", $time, cur_test, what, got, exp);
        test_errs++;
        error_count++;
    endtask

    task automatic close_test();
        if (prev_test != 0) begin
            $display("Test %0d finished with %0d errors", prev_test, test_errs);
            tests_done++;
        end
        test_errs = 0;
    endtask

    always @(negedge clk_i) begin
        if (cur_test != prev_test) begin
            close_test();
            prev_test = cur_test;
        end
        if (cur_test == 0 && tests_done > 0) idle_seen = 1'b1;
        if (rst_ni) begin
            if (rd_wr_en_o !== exp_wr_en) flag("rd_wr_en_o", 64'(rd_wr_en_o), 64'(exp_wr_en));
            if (valid_o !== exp_valid) flag("valid_o", 64'(valid_o), 64'(exp_valid));
            if (retired_o !== (live_valid() & ~stall_i))
                flag("retired_o", 64'(retired_o), 64'(live_valid() & ~stall_i));
            if (retire_order_o !== exp_order) flag("retire_order_o", retire_order_o, exp_order);
            if (have_data && rd_data_o !== exp_data) flag("rd_data_o", rd_data_o, exp_data);
            if (have_data && rd_idx_o !== exp_idx) flag("rd_idx_o", 64'(rd_idx_o), 64'(exp_idx));
        end
    end

    task automatic print_counts();
        $display("Tests run: %0d, errors: %0d", tests_done, error_count);
    endtask

endmodule

// File: test/tb_wb_stage.sv
module tb_wb_stage;
    timeunit 1ns;
    timeprecision 1ps;

    typedef struct packed {
        logic               valid;
        logic               squash;
        logic               bubble;
        logic               stall;
        wb_pkg::word_t      pc;
        wb_pkg::word_t      rd_data;
        wb_pkg::reg_idx_t   idx;
        logic               wr_en;
        logic               src_load;
        wb_pkg::word_t      rdata;
        logic               sign;
        wb_pkg::mem_width_e width;
        wb_pkg::byte_off_t  off;
        logic [7:0]         hold;     // Cycles the row is repeated
        logic [7:0]         test;
    } row_t;

    logic clk = 1'b0;
    logic rst_n, squash, bubble, stall, valid, wr_en, src_load, sign;
    wb_pkg::word_t      pc, rd_data, rdata, rd_data_q;
    wb_pkg::reg_idx_t   idx, rd_idx_q;
    wb_pkg::mem_width_e width;
    wb_pkg::byte_off_t  off;
    wb_pkg::order_t     order;
    logic               rd_wr_en_q, valid_q, retired;
    int                 test_num;
    row_t               rows[$];

    always #4 clk = ~clk;   // 8 ns period

    wb_stage dut_i (
        .clk_i(clk), .rst_ni(rst_n), .squash_i(squash), .bubble_i(bubble),
        .stall_i(stall), .valid_i(valid), .pc_i(pc), .rd_data_i(rd_data),
        .rd_idx_i(idx), .rd_wr_en_i(wr_en), .rd_src_load_i(src_load),
        .dmem_rdata_i(rdata), .mem_sign_i(sign), .mem_width_i(width),
        .byte_off_i(off), .rd_data_o(rd_data_q), .rd_idx_o(rd_idx_q),
        .rd_wr_en_o(rd_wr_en_q), .valid_o(valid_q), .retired_o(retired),
        .retire_order_o(order)
    );

    wb_checker chk_i (
        .clk_i(clk), .rst_ni(rst_n), .squash_i(squash), .bubble_i(bubble),
        .stall_i(stall), .valid_i(valid), .pc_i(pc), .rd_data_i(rd_data),
        .rd_idx_i(idx), .rd_wr_en_i(wr_en), .rd_src_load_i(src_load),
        .dmem_rdata_i(rdata), .mem_sign_i(sign), .mem_width_i(width),
        .byte_off_i(off), .rd_data_o(rd_data_q), .rd_idx_o(rd_idx_q),
        .rd_wr_en_o(rd_wr_en_q), .valid_o(valid_q), .retired_o(retired),
        .retire_order_o(order), .test_num_i(test_num)
    );

    // Pipeline result row with the load fields parked
    task automatic add_alu(input logic v, input logic sq, input logic bb, input logic st,
                           input wb_pkg::word_t p, input wb_pkg::word_t d,
                           input wb_pkg::reg_idx_t i, input int hold, input int t);
        rows.push_back('{v, sq, bb, st, p, d, i, 1'b1, 1'b0, '0, 1'b0,
                         wb_pkg::MEM_DOUBLE, 3'd0, 8'(hold), 8'(t)});
    endtask

    task automatic build_table();
        wb_pkg::word_t pats[2];
        wb_pkg::word_t p;
        pats[0] = 64'h807F_C33C_A55A_FF01;   // Half and word lanes negative
        pats[1] = 64'h7F80_3CC3_5AA5_01FF;   // Half and word lanes positive
        p = 64'h1000;
        // Test 1 walks every width, offset and sign
        for (int k = 0; k < 2; k++)
            for (int w = 0; w < 4; w++)
                for (int o = 0; o < 8; o++)
                    for (int s = 0; s < 2; s++) begin
                        rows.push_back('{1'b1, 1'b0, 1'b0, 1'b0, p, 64'hDEAD,
                            5'(o + 1), 1'b1, 1'b1, pats[k], 1'(s),
                            wb_pkg::mem_width_e'(4'b0001 << w), 3'(o), 8'd1, 8'd1});
                        p += 4;
                    end
        rows.push_back('{1'b1, 1'b0, 1'b0, 1'b0, p, 64'hDEAD, 5'd3, 1'b1, 1'b1,
                         pats[0], 1'b1, wb_pkg::mem_width_e'(4'b0011), 3'd0, 8'd1, 8'd1});
        // Test 2 takes the pipeline result
        add_alu(1, 0, 0, 0, 64'h2000, 64'h0123_4567_89AB_CDEF, 5'd7, 1, 2);
        add_alu(1, 0, 0, 0, 64'h2004, 64'hFFFF_0000_FFFF_0000, 5'd31, 1, 2);
        // Test 3 gives one pulse for a held instruction
        add_alu(1, 0, 0, 0, 64'h3000, 64'h33, 5'd5, 4, 3);
        add_alu(1, 0, 0, 0, 64'h3004, 64'h34, 5'd5, 1, 3);
        // Decoder enable low so no pulse
        rows.push_back('{1'b1, 1'b0, 1'b0, 1'b0, 64'h3008, 64'h35, 5'd5, 1'b0, 1'b0,
                         '0, 1'b0, wb_pkg::MEM_DOUBLE, 3'd0, 8'd1, 8'd3});
        // Test 4 covers squash, bubble and a squash inside a stall
        add_alu(1, 1, 0, 0, 64'h4000, 64'h41, 5'd6, 1, 4);
        add_alu(1, 0, 1, 0, 64'h4004, 64'h42, 5'd6, 1, 4);
        add_alu(1, 1, 0, 1, 64'h4008, 64'h43, 5'd8, 1, 4);
        add_alu(1, 0, 0, 1, 64'h4008, 64'h43, 5'd8, 2, 4);
        add_alu(1, 0, 0, 0, 64'h4008, 64'h43, 5'd8, 1, 4);
        add_alu(1, 0, 0, 0, 64'h400C, 64'h44, 5'd9, 1, 4);
        // Test 5 stall holds data and blocks retirement
        add_alu(1, 0, 0, 0, 64'h5000, 64'h51, 5'd10, 1, 5);
        add_alu(1, 0, 0, 1, 64'h5004, 64'h52, 5'd11, 3, 5);
        add_alu(1, 0, 0, 0, 64'h5004, 64'h52, 5'd11, 1, 5);
        // Test 6 order counter with gaps
        add_alu(0, 0, 0, 0, 64'h6000, 64'h61, 5'd12, 2, 6);
        add_alu(1, 0, 0, 0, 64'h6004, 64'h62, 5'd12, 1, 6);
        add_alu(0, 0, 0, 0, 64'h6008, 64'h63, 5'd13, 1, 6);
        add_alu(1, 0, 0, 0, 64'h600C, 64'h64, 5'd14, 3, 6);
    endtask

    task automatic apply_row(input row_t r);
        {valid, squash, bubble, stall} = {r.valid, r.squash, r.bubble, r.stall};
        {pc, rd_data, idx, wr_en, src_load} = {r.pc, r.rd_data, r.idx, r.wr_en, r.src_load};
        {rdata, sign, off} = {r.rdata, r.sign, r.off};
        width    = r.width;
        test_num = int'(r.test);
    endtask

    initial begin
        int waited;
        rst_n = 1'b0;
        apply_row('{default: '0, width: wb_pkg::MEM_DOUBLE});
        build_table();
        repeat (3) @(posedge clk);
        #1 rst_n = 1'b1;
        foreach (rows[n]) begin
            for (int h = 0; h < int'(rows[n].hold); h++) begin
                apply_row(rows[n]);
                @(posedge clk);
                #1;
            end
        end
        apply_row('{default: '0, width: wb_pkg::MEM_DOUBLE});   // Idle row flushes the last test
        waited = 0;
        while (!chk_i.idle_seen && waited < 20) begin
            @(posedge clk);
            waited++;
        end
        if (!chk_i.idle_seen) begin
            $display("Timed out waiting for the checker to finish the last test");
            $display("Done: errors found");
            $finish;
        end else begin
            repeat (2) @(posedge clk);
            chk_i.print_counts();
            if (chk_i.error_count == 0) begin
                $display("Done: no errors");
            end else begin
                $display("Done: errors found");
            end
            $finish;
        end
    end

endmodule

// File: build.f
src/wb_pkg.sv
src/wb_load_if.sv
src/wb_validity.sv
src/wb_load_align.sv
src/wb_rf_write.sv
src/wb_retire.sv
src/wb_stage.sv
test/wb_checker.sv
test/tb_wb_stage.sv

// File: Makefile
# Verilator flow for the writeback stage testbench

VERILATOR ?= verilator
TOP       ?= tb_wb_stage
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing
PASS_MSG  ?= Done: no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)
